/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dac_tx
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/dac_tx_top.sv */
// transmit top level with buffer, framer and data and frame output stages
`timescale 1ns/1ns
`include "tx_settings.svh"

module dac_tx_top import tx_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  sample_t in_data,
  output logic    credit,
  output lane_t   dout_p,
  output lane_t   dout_n,
  output logic    frame_p,
  output logic    frame_n
);

  logic    fifo_valid;
  sample_t fifo_data;
  logic    fifo_pop;
  lane_t   rise_lanes;
  lane_t   fall_lanes;
  logic    frame_rise;
  logic    frame_fall;

  //////////////////////////////////////////////////////////////////////
  // buffering and framing
  //////////////////////////////////////////////////////////////////////

  tx_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .credit     (credit),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop)
  );

  tx_framer u_framer (
    .clk        (clk),
    .rst        (rst),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop),
    .rise_lanes (rise_lanes),
    .fall_lanes (fall_lanes),
    .frame_rise (frame_rise),
    .frame_fall (frame_fall)
  );

  //////////////////////////////////////////////////////////////////////
  // DDR LVDS outputs
  //////////////////////////////////////////////////////////////////////

  data_out #(
    .SIGNAL_TYPE ("LVDS"),
    .DATA_WIDTH  (`TX_LANES),
    .DATA_RATE   (2)
  ) u_data_out (
    .clk    (clk),
    .rst    (rst),
    .dout   (rise_lanes),
    .dout_2 (fall_lanes),
    .dout_p (dout_p),
    .dout_n (dout_n)
  );

  // single lane marking valid words
  data_out #(
    .SIGNAL_TYPE ("LVDS"),
    .DATA_WIDTH  (1),
    .DATA_RATE   (2)
  ) u_frame_out (
    .clk    (clk),
    .rst    (rst),
    .dout   (frame_rise),
    .dout_2 (frame_fall),
    .dout_p (frame_p),
    .dout_n (frame_n)
  );

endmodule

/* hdl/data_out.sv */
// output register stage with pass-through, SDR or DDR and CMOS or LVDS output
`timescale 1ns/1ns

module data_out #(
  parameter string SIGNAL_TYPE = "CMOS",
  parameter int    DATA_WIDTH  = 1,
  parameter int    DATA_RATE   = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] dout,
  input  logic [DATA_WIDTH-1:0] dout_2,
  output logic [DATA_WIDTH-1:0] dout_p,
  output logic [DATA_WIDTH-1:0] dout_n
);

  logic [DATA_WIDTH-1:0] dout_ddr;

  //////////////////////////////////////////////////////////////////////
  // rate stage
  //////////////////////////////////////////////////////////////////////

  generate
    if (DATA_RATE == 2) begin : g_ddr
      logic [DATA_WIDTH-1:0] d1_q;
      logic [DATA_WIDTH-1:0] d2_q;

      // both halves captured on the same rising edge
      always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
          d1_q <= '0;
          d2_q <= '0;
        end else begin
          d1_q <= dout;
          d2_q <= dout_2;
        end
      end

      // first half while clk high, second half while low
      assign dout_ddr = clk ? d1_q : d2_q;
    end else if (DATA_RATE == 1) begin : g_sdr
      logic [DATA_WIDTH-1:0] dout_q;

      always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
          dout_q <= '0;
        end else begin
          dout_q <= dout;
        end
      end

      assign dout_ddr = dout_q;
    end else begin : g_pass
      assign dout_ddr = dout;
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // output buffer
  //////////////////////////////////////////////////////////////////////

  generate
    if (SIGNAL_TYPE == "LVDS") begin : g_lvds
      assign dout_p = dout_ddr;
      assign dout_n = ~dout_ddr;
    end else begin : g_cmos
      // single ended, no complement lane
      assign dout_p = dout_ddr;
      assign dout_n = '0;
    end
  endgenerate

endmodule

/* hdl/tx_fifo.sv */
// sample buffer with push input, pop output and per-pop credit return
`timescale 1ns/1ns
`include "tx_settings.svh"

module tx_fifo import tx_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  sample_t in_data,
  output logic    credit,
  output logic    fifo_valid,
  output sample_t fifo_data,
  input  logic    fifo_pop
);

  localparam int DEPTH = `TX_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  sample_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // a pop on an empty buffer is ignored
  assign pop = fifo_pop && fifo_valid;

  assign fifo_valid = (count != '0);
  assign fifo_data  = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per freed entry, a cycle after the pop
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credit <= 1'b0;
    end else begin
      credit <= pop;
    end
  end

endmodule

/* hdl/tx_framer.sv */
// training, idle and data FSM producing lane halves and the frame lane
`timescale 1ns/1ns
`include "tx_settings.svh"

module tx_framer import tx_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    fifo_valid,
  input  sample_t fifo_data,
  output logic    fifo_pop,
  output lane_t   rise_lanes,
  output lane_t   fall_lanes,
  output logic    frame_rise,
  output logic    frame_fall
);

  localparam int LANES = `TX_LANES;
  localparam int TRAIN_LEN = `TX_TRAIN_LEN;
  localparam int CNT_W = (TRAIN_LEN > 1) ? $clog2(TRAIN_LEN) : 1;
  localparam logic [CNT_W-1:0] TRAIN_LAST = CNT_W'(TRAIN_LEN - 1);
  localparam lane_t TRAIN_PAT = lane_t'(`TX_TRAIN_PATTERN);

  tx_state_t        state;
  logic [CNT_W-1:0] train_cnt;

  // take a word whenever one is waiting and training is done
  assign fifo_pop = (state != ST_TRAIN) && fifo_valid;

  // the rising frame half is high exactly while a word sits in the lane registers
  assign frame_rise = (state == ST_DATA);

  //////////////////////////////////////////////////////////////////////
  // state and training counter
  //////////////////////////////////////////////////////////////////////

  // state tracks what the output registers currently hold
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ST_TRAIN;
      train_cnt <= '0;
    end else begin
      case (state)
        ST_TRAIN: begin
          train_cnt <= train_cnt + 1'b1;
          if (train_cnt == TRAIN_LAST) begin
            state <= ST_IDLE;
          end
        end
        ST_IDLE, ST_DATA: begin
          state <= fifo_valid ? ST_DATA : ST_IDLE;
        end
        default: begin
          state <= ST_TRAIN;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane halves and frame marker
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rise_lanes <= '0;
      fall_lanes <= '0;
      frame_fall <= 1'b0;
    end else if (state == ST_TRAIN) begin
      // pattern on rise, complement on fall
      rise_lanes <= TRAIN_PAT;
      fall_lanes <= ~TRAIN_PAT;
      frame_fall <= 1'b0;
    end else if (fifo_pop) begin
      rise_lanes <= fifo_data[2*LANES-1:LANES];
      fall_lanes <= fifo_data[LANES-1:0];
      frame_fall <= 1'b0;
    end else begin
      // idle word
      rise_lanes <= '0;
      fall_lanes <= '0;
      frame_fall <= 1'b0;
    end
  end

endmodule

/* hdl/tx_pkg.sv */
// framer state enum and sample word / lane half types
`include "tx_settings.svh"

package tx_pkg;

  //////////////////////////////////////////////////////////////////////
  // framer states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_TRAIN,
    ST_IDLE,
    ST_DATA
  } tx_state_t;

  //////////////////////////////////////////////////////////////////////
  // data words
  //////////////////////////////////////////////////////////////////////

  // upper half goes out on the rising half cycle, lower half on the falling
  typedef logic [2*`TX_LANES-1:0] sample_t;

  // one half cycle across the data lanes
  typedef logic [`TX_LANES-1:0] lane_t;

endpackage

/* hdl/tx_settings.svh */
// lane count, buffer depth and training sequence macros for the LVDS transmit path
`ifndef TX_SETTINGS_SVH
`define TX_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// physical lanes
//////////////////////////////////////////////////////////////////////

// data lanes per half cycle, a sample word is twice this
`define TX_LANES 8

//////////////////////////////////////////////////////////////////////
// flow control and link bring-up
//////////////////////////////////////////////////////////////////////

// buffer entries, also the credits the sender starts with
`define TX_FIFO_DEPTH 8

// cycles of training after reset
`define TX_TRAIN_LEN 16

// rising half value, falling half carries the complement
`define TX_TRAIN_PATTERN 8'hA5

`endif

/* project.f */
+incdir+hdl
hdl/tx_pkg.sv
hdl/tx_fifo.sv
hdl/tx_framer.sv
hdl/data_out.sv
hdl/dac_tx_top.sv
verif/tb_dac_tx.sv

/* verif/tb_dac_tx.sv */
// testbench for dac_tx_top with clock, reset, trace reader, credit sender, DDR sampler and checks
`timescale 1ns/1ns
`include "tx_settings.svh"

module tb_dac_tx import tx_pkg::*; ();

  localparam int    DEPTH     = `TX_FIFO_DEPTH;
  localparam int    TRAIN_LEN = `TX_TRAIN_LEN;
  localparam lane_t TRAIN_PAT = lane_t'(`TX_TRAIN_PATTERN);
  localparam int    MAX_WORDS = 256;
  // what a sampled cycle is expected to carry
  localparam int    K_QUIET   = 0;
  localparam int    K_TRAIN   = 1;
  localparam int    K_WORD    = 2;
  localparam int    K_IDLE    = 3;

  logic    clk;
  logic    rst;
  logic    in_valid;
  sample_t in_data;
  logic    credit;
  lane_t   dout_p;
  lane_t   dout_n;
  logic    frame_p;
  logic    frame_n;

  sample_t     words [MAX_WORDS];
  int          gaps [MAX_WORDS];
  sample_t     exp_q [$];
  int          n_words;
  int          sum_gaps;
  int          credits;
  int          credit_total;
  int          matched;
  int          limit;
  int          cycles;
  logic [31:0] lfsr;

  dac_tx_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_data  (in_data),
    .credit   (credit),
    .dout_p   (dout_p),
    .dout_n   (dout_n),
    .frame_p  (frame_p),
    .frame_n  (frame_n)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_fail();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_lanes(lane_t got, lane_t exp, string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      stop_fail();
    end
  endtask

  task automatic check_bit(logic got, logic exp, string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      stop_fail();
    end
  endtask

  task automatic check_count(int got, int exp, string msg);
    if (got != exp) begin
      $display("[FAIL] %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      stop_fail();
    end
  endtask

  // taps x^32 + x^22 + x^2 + x + 1 with the new bit entering at bit 0
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic read_trace();
    int      fd;
    int      code;
    string   line;
    sample_t w;
    int      g;
    fd = $fopen("verif/tx_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open trace file verif/tx_trace.txt");
      stop_fail();
    end
    n_words  = 0;
    sum_gaps = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // comment and blank lines do not scan as a word
      if (code != 0 && $sscanf(line, "%h %d", w, g) == 2) begin
        if (n_words == MAX_WORDS) begin
          $display("ERROR: trace file holds more than %0d words", MAX_WORDS);
          stop_fail();
        end
        words[n_words] = w;
        gaps[n_words]  = g;
        sum_gaps += g;
        exp_q.push_back(w);
        n_words++;
      end
    end
    $fclose(fd);
  endtask

  // one sender cycle with credit pulses counted at the falling edge
  task automatic next_cycle();
    @(negedge clk);
    if (credit) begin
      credits++;
      credit_total++;
      if (credits > DEPTH) begin
        $display("ERROR: credit pulse with all %0d buffer entries already free", DEPTH);
        stop_fail();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // sender
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [1:0] stall;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_data      = '0;
    credits      = DEPTH;
    credit_total = 0;
    matched      = 0;
    cycles       = 0;
    limit        = 0;
    lfsr         = 32'h81be;
    read_trace();
    if (n_words == 0) begin
      $display("ERROR: trace file holds no words");
      stop_fail();
    end
    limit = TRAIN_LEN + n_words * 8 + sum_gaps + 100;
    repeat (3) next_cycle();
    rst = 1'b0;
    for (int i = 0; i < n_words; i++) begin
      while (credits == 0) begin
        next_cycle();
      end
      in_valid = 1'b1;
      in_data  = words[i];
      credits--;
      next_cycle();
      in_valid = 1'b0;
      // two random bits give 0 to 3 extra stall cycles
      lfsr  = lfsr_step(lfsr);
      stall[0] = lfsr[0];
      lfsr  = lfsr_step(lfsr);
      stall[1] = lfsr[0];
      repeat (gaps[i] + int'(stall)) next_cycle();
    end
    // each credit is due a cycle before its word reaches the outputs
    while (matched < n_words) begin
      next_cycle();
    end
    check_count(matched, n_words, "framed words");
    check_count(exp_q.size(), 0, "words still expected");
    check_count(credit_total, n_words, "credit pulses");
    check_count(credits, DEPTH, "credits after drain");
    $display("TEST OK");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // DDR sampler
  //////////////////////////////////////////////////////////////////////

  initial begin
    int      cyc;
    int      kind;
    sample_t cur;
    cyc  = 0;
    kind = K_QUIET;
    cur  = '0;
    forever begin
      @(posedge clk);
      #1;
      check_lanes(dout_n, ~dout_p, "data pair, rising half");
      check_bit(frame_n, ~frame_p, "frame pair, rising half");
      if (rst) begin
        kind = K_QUIET;
      end else begin
        cyc++;
        // framer register plus output register before training shows
        if (cyc == 1) begin
          kind = K_QUIET;
        end else if (cyc <= TRAIN_LEN + 1) begin
          kind = K_TRAIN;
        end else if (frame_p) begin
          kind = K_WORD;
        end else begin
          kind = K_IDLE;
        end
      end
      case (kind)
        K_TRAIN: begin
          check_lanes(dout_p, TRAIN_PAT, "training, rising half");
          check_bit(frame_p, 1'b0, "frame during training, rising half");
        end
        K_WORD: begin
          if (exp_q.size() == 0) begin
            $display("ERROR: frame lane marked a word after all words were seen");
            stop_fail();
          end
          cur = exp_q.pop_front();
          check_lanes(dout_p, cur[2*`TX_LANES-1:`TX_LANES], "word upper half");
        end
        K_IDLE: begin
          check_lanes(dout_p, '0, "idle, rising half");
        end
        default: begin
          check_bit(frame_p, 1'b0, "frame in reset, rising half");
        end
      endcase

      @(negedge clk);
      #1;
      check_lanes(dout_n, ~dout_p, "data pair, falling half");
      check_bit(frame_n, ~frame_p, "frame pair, falling half");
      check_bit(frame_p, 1'b0, "frame, falling half");
      case (kind)
        K_TRAIN: check_lanes(dout_p, ~TRAIN_PAT, "training, falling half");
        K_WORD: begin
          check_lanes(dout_p, cur[`TX_LANES-1:0], "word lower half");
          matched++;
        end
        K_IDLE:  check_lanes(dout_p, '0, "idle, falling half");
        default: check_lanes(dout_p, '0, "reset, falling half");
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    wait (limit > 0);
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("ERROR: timeout, trace not finished after %0d cycles", limit);
        stop_fail();
      end
    end
  end

endmodule

/* verif/tx_trace.txt */
# columns: sample word (hex, upper byte on rising half), idle gap cycles after it (decimal)
# words are framed in this order
1234 0
abcd 0
0f0f 0
f0f0 0
5a5a 0
a5a5 0
0001 0
8000 0
ffff 0
0000 0
3c3c 0
c3c3 0
1111 2
2222 0
4444 1
8888 0
7e81 3
0102 0
0408 0
1020 0
4080 5
dead 0
beef 0
cafe 1
f00d 0
9669 0
6996 2
55aa 0
aa55 0
00ff 4
ff00 0
1357 0
2468 1
9bdf 0
ace0 0
7777 0
